/* include/archMap_config.svh */
`ifndef ARCHMAP_CONFIG_SVH
`define ARCHMAP_CONFIG_SVH

// Architectural register file size.
`define NUM_LOG_REGS 32

// Logical register index width.
`define LOG_REG_BITS 5

// Physical register index width, 128 physical registers.
`define PHYS_REG_BITS 7

// Retire lanes per cycle. Also the recovery group size.
// NUM_LOG_REGS must be a multiple of this.
`define COMMIT_WIDTH 4

`endif

/* verilog/archMapPkg.sv */
`include "archMap_config.svh"

package archMapPkg;

  // Index into the architectural register file.
  typedef logic [`LOG_REG_BITS-1:0] logRegT;

  // Index into the physical register file.
  typedef logic [`PHYS_REG_BITS-1:0] physRegT;

  // One bit per retire lane, lane 0 is the oldest.
  typedef logic [`COMMIT_WIDTH-1:0] laneMaskT;

  // Per-lane buses.
  typedef logRegT [`COMMIT_WIDTH-1:0] logRegLanesT;   // Logical index per lane.
  typedef physRegT [`COMMIT_WIDTH-1:0] physRegLanesT; // Physical index per lane.

endpackage

/* verilog/commitIf.sv */
// Decoded retire group, shared by decoder, map RAM and output stage.
interface commitIf import archMapPkg::*; ();

  laneMaskT     commitValid; // Lane carries a destination.
  logRegLanesT  logDest;     // Logical destination per lane.
  physRegLanesT newPhys;     // New physical destination per lane.
  laneMaskT     writeEn;     // Lane updates the table.
  laneMaskT     superseded;  // A younger valid lane has the same destination.

  // Decoder produces everything.
  modport decoder (
    output commitValid,
    output logDest,
    output newPhys,
    output writeEn,
    output superseded
  );

  // Map RAM only needs the write side.
  modport ram (
    input writeEn,
    input logDest,
    input newPhys
  );

  // Output stage picks what gets released.
  modport result (
    input commitValid,
    input logDest,
    input newPhys,
    input superseded
  );

endinterface

/* verilog/mapReadIf.sv */
// Four asynchronous read ports into the map RAM.
interface mapReadIf import archMapPkg::*; ();

  logRegLanesT  readAddr; // Logical index per read port.
  physRegLanesT readData; // Current mapping per read port.

  // Output stage steers the addresses.
  modport requester (
    output readAddr,
    input  readData
  );

  modport ram (
    input  readAddr,
    output readData
  );

endinterface

/* verilog/commitDecode.sv */
`include "archMap_config.svh"

// Group dependency check for the retire lanes.
// Only the youngest valid lane per logical destination writes the table.
module commitDecode import archMapPkg::*; (
  input  laneMaskT       commitValid_i,   // Lane valid from the active list.
  input  logRegLanesT    packetLogDest_i, // Logical destinations.
  input  physRegLanesT   packetPhys_i,    // New physical destinations.
  input  logic           recoverFlag_i,   // Commits are ignored during recovery.
  commitIf.decoder       commit
);

  laneMaskT supersededLanes; // Older lanes hidden by a younger one.

  // Lane i is superseded when any younger valid lane names the same register.
  always_comb begin
    supersededLanes = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      for (int j = i + 1; j < `COMMIT_WIDTH; j++) begin
        if (commitValid_i[i] && commitValid_i[j] &&
            (packetLogDest_i[i] == packetLogDest_i[j])) begin
          supersededLanes[i] = 1'b1;
        end
      end
    end
  end

  assign commit.commitValid = commitValid_i;
  assign commit.logDest     = packetLogDest_i;
  assign commit.newPhys     = packetPhys_i;
  assign commit.superseded  = supersededLanes;

  // Surviving valid lanes write. Nothing writes while recovering.
  assign commit.writeEn = recoverFlag_i ? '0 : (commitValid_i & ~supersededLanes);

endmodule

/* verilog/archMapRam.sv */
`include "archMap_config.svh"

// Architectural map storage.
// Four write ports applied at the edge, four asynchronous read ports.
module archMapRam import archMapPkg::*; (
  input  logic      clk,
  input  logic      reset,
  commitIf.ram      commit,
  mapReadIf.ram     mapRead
);

  physRegT mapTable [`NUM_LOG_REGS]; // Committed mapping per logical register.
  logic    writeCollision;           // Two enabled lanes target one entry.

  // Identity map out of reset, then committed writes.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_LOG_REGS; i++) begin
        mapTable[i] <= physRegT'(i);
      end
    end else begin
      for (int k = 0; k < `COMMIT_WIDTH; k++) begin
        if (commit.writeEn[k]) begin
          mapTable[commit.logDest[k]] <= commit.newPhys[k];
        end
      end
    end
  end

  // Reads see the value from before this cycle's writes.
  always_comb begin
    for (int k = 0; k < `COMMIT_WIDTH; k++) begin
      mapRead.readData[k] = mapTable[mapRead.readAddr[k]];
    end
  end

  // Write port overlap detect.
  always_comb begin
    writeCollision = 1'b0;
    for (int a = 0; a < `COMMIT_WIDTH; a++) begin
      for (int b = a + 1; b < `COMMIT_WIDTH; b++) begin
        if (commit.writeEn[a] && commit.writeEn[b] &&
            (commit.logDest[a] == commit.logDest[b])) begin
          writeCollision = 1'b1;
        end
      end
    end
  end

  // The decoder upstream must hand over disjoint write addresses.
  noWriteCollision: assert property (
    @(posedge clk) disable iff (reset) !writeCollision
  ) else $error("archMapRam: write address collision");

endmodule

/* verilog/releaseRecover.sv */
`include "archMap_config.svh"

// Release selection, recovery walk and read-address steering.
module releaseRecover import archMapPkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           recoverFlag_i,   // Level, one group per cycle.
  commitIf.result        commit,
  mapReadIf.requester    mapRead,
  output laneMaskT       releasedValid_o, // To the free list.
  output physRegLanesT   releasedPhys_o,
  output logRegLanesT    recoverLog_o,    // To the rename map table.
  output physRegLanesT   recoverPhys_o
);

  localparam int NumGroups = `NUM_LOG_REGS / `COMMIT_WIDTH;
  localparam int GroupBits = (NumGroups > 1) ? $clog2(NumGroups) : 1;

  logic [GroupBits-1:0] groupCnt;  // Recovery group being sent.
  logRegLanesT          walkAddr;  // Registers of the current group.

  // Group k covers registers groupCnt*COMMIT_WIDTH + lane.
  always_comb begin
    for (int k = 0; k < `COMMIT_WIDTH; k++) begin
      walkAddr[k] = logRegT'((`COMMIT_WIDTH * groupCnt) + k);
    end
  end

  // Commit destinations normally, walk addresses while recovering.
  assign mapRead.readAddr = recoverFlag_i ? walkAddr : commit.logDest;

  // Nothing released while recovering.
  assign releasedValid_o = recoverFlag_i ? '0 : commit.commitValid;

  // Superseded lane gives back its own register, else the replaced mapping.
  always_comb begin
    for (int k = 0; k < `COMMIT_WIDTH; k++) begin
      releasedPhys_o[k] = commit.superseded[k] ? commit.newPhys[k]
                                               : mapRead.readData[k];
    end
  end

  assign recoverLog_o  = walkAddr;         // Logical half of the packet.
  assign recoverPhys_o = mapRead.readData; // Valid for the RMT when recoverFlag_i is high.

  // Walk advances each recovery cycle and wraps after the last group.
  // Holds its value once recovery ends.
  always_ff @(posedge clk) begin
    if (reset) begin
      groupCnt <= '0;
    end else if (recoverFlag_i) begin
      if (groupCnt == GroupBits'(NumGroups - 1)) begin
        groupCnt <= '0;
      end else begin
        groupCnt <= groupCnt + 1'b1;
      end
    end
  end

  // Walk never addresses past the table.
  groupCntInRange: assert property (
    @(posedge clk) disable iff (reset) recoverFlag_i |=> (int'(groupCnt) < NumGroups)
  ) else $error("releaseRecover: recovery group out of range");

endmodule

/* verilog/archMapTable.sv */
// Architectural map table, top level.
// Flat per-lane ports packed into lane arrays for the internal blocks.
module archMapTable import archMapPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    recoverFlag_i,      // Branch mispredict or exception walk.

  input  logic    commitValid0_i,     // Lane 0 is the oldest.
  input  logRegT  commitLogDest0_i,
  input  physRegT commitPhys0_i,
  input  logic    commitValid1_i,
  input  logRegT  commitLogDest1_i,
  input  physRegT commitPhys1_i,
  input  logic    commitValid2_i,
  input  logRegT  commitLogDest2_i,
  input  physRegT commitPhys2_i,
  input  logic    commitValid3_i,     // Lane 3 is the youngest.
  input  logRegT  commitLogDest3_i,
  input  physRegT commitPhys3_i,

  output logic    releasedValid0_o,   // Free list side.
  output physRegT releasedPhys0_o,
  output logic    releasedValid1_o,
  output physRegT releasedPhys1_o,
  output logic    releasedValid2_o,
  output physRegT releasedPhys2_o,
  output logic    releasedValid3_o,
  output physRegT releasedPhys3_o,

  output logRegT  recoverLog0_o,      // Rename map table side.
  output physRegT recoverPhys0_o,
  output logRegT  recoverLog1_o,
  output physRegT recoverPhys1_o,
  output logRegT  recoverLog2_o,
  output physRegT recoverPhys2_o,
  output logRegT  recoverLog3_o,
  output physRegT recoverPhys3_o
);

  laneMaskT     commitValidLanes;
  logRegLanesT  commitLogDestLanes;
  physRegLanesT commitPhysLanes;
  laneMaskT     releasedValidLanes;
  physRegLanesT releasedPhysLanes;
  logRegLanesT  recoverLogLanes;
  physRegLanesT recoverPhysLanes;

  // Pack inputs, lane 0 in the low slot.
  assign commitValidLanes   = {commitValid3_i, commitValid2_i, commitValid1_i, commitValid0_i};
  assign commitLogDestLanes = {commitLogDest3_i, commitLogDest2_i,
                               commitLogDest1_i, commitLogDest0_i};
  assign commitPhysLanes    = {commitPhys3_i, commitPhys2_i, commitPhys1_i, commitPhys0_i};

  // Unpack outputs.
  assign releasedValid0_o = releasedValidLanes[0];
  assign releasedValid1_o = releasedValidLanes[1];
  assign releasedValid2_o = releasedValidLanes[2];
  assign releasedValid3_o = releasedValidLanes[3];
  assign releasedPhys0_o  = releasedPhysLanes[0];
  assign releasedPhys1_o  = releasedPhysLanes[1];
  assign releasedPhys2_o  = releasedPhysLanes[2];
  assign releasedPhys3_o  = releasedPhysLanes[3];
  assign recoverLog0_o    = recoverLogLanes[0];
  assign recoverLog1_o    = recoverLogLanes[1];
  assign recoverLog2_o    = recoverLogLanes[2];
  assign recoverLog3_o    = recoverLogLanes[3];
  assign recoverPhys0_o   = recoverPhysLanes[0];
  assign recoverPhys1_o   = recoverPhysLanes[1];
  assign recoverPhys2_o   = recoverPhysLanes[2];
  assign recoverPhys3_o   = recoverPhysLanes[3];

  commitIf  commitBus ();  // Decoded group.
  mapReadIf mapReadBus (); // RAM read ports.

  commitDecode decode (
    .commitValid_i   (commitValidLanes),
    .packetLogDest_i (commitLogDestLanes),
    .packetPhys_i    (commitPhysLanes),
    .recoverFlag_i   (recoverFlag_i),
    .commit          (commitBus.decoder)
  );

  archMapRam mapRam (
    .clk     (clk),
    .reset   (reset),
    .commit  (commitBus.ram),
    .mapRead (mapReadBus.ram)
  );

  releaseRecover outStage (
    .clk             (clk),
    .reset           (reset),
    .recoverFlag_i   (recoverFlag_i),
    .commit          (commitBus.result),
    .mapRead         (mapReadBus.requester),
    .releasedValid_o (releasedValidLanes),
    .releasedPhys_o  (releasedPhysLanes),
    .recoverLog_o    (recoverLogLanes),
    .recoverPhys_o   (recoverPhysLanes)
  );

endmodule

/* verif/archMapTableTb.sv */
`include "archMap_config.svh"

// Architectural map table testbench.
// Table-driven, one row per clock, reference map kept alongside.
module archMapTableTb import archMapPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ResetCycles = 5;
  localparam int NumGroups   = `NUM_LOG_REGS / `COMMIT_WIDTH;
  localparam int RandomRows  = 24;
  localparam int CycleMargin = 20;

  logic         clk = 1'b0;
  logic         reset;
  logic         recoverFlag;
  laneMaskT     commitValid;
  logRegLanesT  commitLogDest;
  physRegLanesT commitPhys;
  laneMaskT     releasedValid;  // Free list side.
  physRegLanesT releasedPhys;
  logRegLanesT  recoverLog;     // Rename map table side.
  physRegLanesT recoverPhys;

  // Stimulus table, one entry per cycle.
  string        rowName [$];
  bit           rowRecover [$];
  laneMaskT     rowValid [$];
  logRegLanesT  rowDest [$];
  physRegLanesT rowPhys [$];

  physRegT refMap [`NUM_LOG_REGS]; // Expected committed mapping.
  int      refGroup;               // Expected recovery group.
  int      errorCount = 0;
  int      cycleCount = 0;
  int      cycleLimit = 0;         // Set once the table is built.

  archMapTable UUT (
    .clk (clk), .reset (reset), .recoverFlag_i (recoverFlag),
    .commitValid0_i (commitValid[0]), .commitLogDest0_i (commitLogDest[0]),
    .commitPhys0_i (commitPhys[0]),
    .commitValid1_i (commitValid[1]), .commitLogDest1_i (commitLogDest[1]),
    .commitPhys1_i (commitPhys[1]),
    .commitValid2_i (commitValid[2]), .commitLogDest2_i (commitLogDest[2]),
    .commitPhys2_i (commitPhys[2]),
    .commitValid3_i (commitValid[3]), .commitLogDest3_i (commitLogDest[3]),
    .commitPhys3_i (commitPhys[3]),
    .releasedValid0_o (releasedValid[0]), .releasedPhys0_o (releasedPhys[0]),
    .releasedValid1_o (releasedValid[1]), .releasedPhys1_o (releasedPhys[1]),
    .releasedValid2_o (releasedValid[2]), .releasedPhys2_o (releasedPhys[2]),
    .releasedValid3_o (releasedValid[3]), .releasedPhys3_o (releasedPhys[3]),
    .recoverLog0_o (recoverLog[0]), .recoverPhys0_o (recoverPhys[0]),
    .recoverLog1_o (recoverLog[1]), .recoverPhys1_o (recoverPhys[1]),
    .recoverLog2_o (recoverLog[2]), .recoverPhys2_o (recoverPhys[2]),
    .recoverLog3_o (recoverLog[3]), .recoverPhys3_o (recoverPhys[3])
  );

  always #10 clk = ~clk; // 20 ns period.

  // Run limit, two cycles per row plus reset and slack.
  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("** Error: run did not finish within %0d cycles", cycleLimit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Youngest valid lane naming this register owns the write.
  function automatic bit laneSurvives(laneMaskT valid, logRegLanesT dest, int lane);
    for (int j = `COMMIT_WIDTH - 1; j >= 0; j--) begin
      if (valid[j] && dest[j] == dest[lane]) begin
        return j == lane;
      end
    end
    return 1'b0;
  endfunction

  task automatic pushRow(input string name, input bit rec, input laneMaskT valid,
                         input logRegLanesT dest, input physRegLanesT phys);
    rowName.push_back(name);
    rowRecover.push_back(rec);
    rowValid.push_back(valid);
    rowDest.push_back(dest);
    rowPhys.push_back(phys);
  endtask

  task automatic addCommit(input string name, input bit rec, input laneMaskT valid,
                           input logRegT d0, d1, d2, d3, input physRegT p0, p1, p2, p3);
    pushRow(name, rec, valid, {d3, d2, d1, d0}, {p3, p2, p1, p0}); // Lane 0 low.
  endtask

  // Recovery cycles with idle lanes.
  task automatic addWalk(input string name, input int count);
    for (int n = 0; n < count; n++) begin
      addCommit(name, 1'b1, '0, 0, 0, 0, 0, 0, 0, 0, 0);
    end
  endtask

  task automatic addRandomRows(input int count);
    int           base;
    logRegLanesT  dest;
    physRegLanesT phys;
    for (int n = 0; n < count; n++) begin
      base = $urandom_range(`NUM_LOG_REGS - 1, 0);
      for (int k = 0; k < `COMMIT_WIDTH; k++) begin
        dest[k] = logRegT'((base + $urandom_range(5, 0)) % `NUM_LOG_REGS); // Narrow window.
        phys[k] = physRegT'($urandom);
      end
      pushRow($sformatf("random%0d", n), 1'b0, laneMaskT'($urandom), dest, phys);
    end
  endtask

  task automatic buildTable();
    addWalk("recoverAfterReset", NumGroups + 1); // Ninth cycle wraps to group 0.
    addCommit("distinctDest", 1'b0, 4'b1111, 3, 9, 17, 30, 40, 41, 42, 43);
    addWalk("walkAfterDistinct", NumGroups);
    addCommit("sameDest", 1'b0, 4'b1111, 5, 6, 5, 5, 50, 51, 52, 53);
    // Lane 2 repeats lane 0's register but is invalid, lane 3 likewise for lane 1.
    addCommit("invalidLanes", 1'b0, 4'b0011, 5, 7, 5, 7, 60, 61, 62, 63);
    addWalk("walkAfterInvalid", NumGroups);
    for (int n = 0; n < NumGroups; n++) begin
      addCommit("commitDuringRecover", 1'b1, 4'b1111, 1, 2, 3, 4, 70, 71, 72, 73);
    end
    addWalk("walkAfterBlocked", NumGroups);
    addRandomRows(RandomRows);
    addWalk("walkAfterRandom", NumGroups);
  endtask

  task automatic driveRow(input int r);
    recoverFlag   = rowRecover[r];
    commitValid   = rowValid[r];
    commitLogDest = rowDest[r];
    commitPhys    = rowPhys[r];
  endtask

  task automatic reportMismatch(input string name, input int lane, input string field,
                                input int expected, input int actual);
    errorCount++;
    $display("** Error %s lane %0d %s: expected %0d, actual %0d",
             name, lane, field, expected, actual);
  endtask

  task automatic checkRow(input int r);
    int      regIdx;
    physRegT expPhys;
    for (int k = 0; k < `COMMIT_WIDTH; k++) begin
      if (rowRecover[r]) begin
        regIdx = refGroup * `COMMIT_WIDTH + k;
        assert (releasedValid[k] == 1'b0)
          else reportMismatch(rowName[r], k, "releasedValid", 0, releasedValid[k]);
        assert (recoverLog[k] == logRegT'(regIdx))
          else reportMismatch(rowName[r], k, "recoverLog", regIdx, recoverLog[k]);
        assert (recoverPhys[k] == refMap[regIdx])
          else reportMismatch(rowName[r], k, "recoverPhys", refMap[regIdx], recoverPhys[k]);
      end else begin
        assert (releasedValid[k] == rowValid[r][k])
          else reportMismatch(rowName[r], k, "releasedValid", rowValid[r][k],
                              releasedValid[k]);
        if (rowValid[r][k]) begin
          // Winner frees the old mapping, a hidden lane frees its own register.
          expPhys = laneSurvives(rowValid[r], rowDest[r], k) ? refMap[rowDest[r][k]]
                                                              : rowPhys[r][k];
          assert (releasedPhys[k] == expPhys)
            else reportMismatch(rowName[r], k, "releasedPhys", expPhys, releasedPhys[k]);
        end
      end
    end
  endtask

  // Apply the row's effect as of the coming edge.
  task automatic updateReference(input int r);
    if (rowRecover[r]) begin
      refGroup = (refGroup + 1) % NumGroups;
    end else begin
      for (int k = 0; k < `COMMIT_WIDTH; k++) begin
        if (rowValid[r][k] && laneSurvives(rowValid[r], rowDest[r], k)) begin
          refMap[rowDest[r][k]] = rowPhys[r][k];
        end
      end
    end
  endtask

  initial begin
    void'($urandom(6156)); // Single seed for the whole run.
    reset         = 1'b1;
    recoverFlag   = 1'b0;
    commitValid   = '0;
    commitLogDest = '0;
    commitPhys    = '0;
    refGroup      = 0;
    for (int i = 0; i < `NUM_LOG_REGS; i++) begin
      refMap[i] = physRegT'(i); // Identity after reset.
    end
    buildTable();
    cycleLimit = 2 * rowName.size() + ResetCycles + CycleMargin;
    repeat (ResetCycles) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int r = 0; r < rowName.size(); r++) begin
      driveRow(r);
      #16;            // Sample just before the next edge.
      checkRow(r);
      updateReference(r);
      @(posedge clk);
      #2;
    end
    recoverFlag = 1'b0;
    commitValid = '0;
    $display("Rows run: %0d, errors: %0d", rowName.size(), errorCount);
    if (errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* archMapTable.f */
+incdir+include
verilog/archMapPkg.sv
verilog/commitIf.sv
verilog/mapReadIf.sv
verilog/commitDecode.sv
verilog/archMapRam.sv
verilog/releaseRecover.sv
verilog/archMapTable.sv
verif/archMapTableTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the architectural map table testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module archMapTableTb \
  -f archMapTable.f -o simv --Mdir obj_dir > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -qx "STATUS: PASS" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }
